/* hdl/video_pkg.sv */
// Video timing definitions

//////////////////////////////////////////////////////////////////////////////
// widths shared by the timing generator and the top level
//////////////////////////////////////////////////////////////////////////////

package video_pkg;

   // horizontal and vertical counters, h_active and v_active
   localparam int hcnt_w  = 16;

   // front porch, sync and back porch lengths
   localparam int porch_w = 8;

endpackage

/* hdl/vram_pkg.sv */
// Pixel store definitions

//////////////////////////////////////////////////////////////////////////////
// pixel format and store geometry
//////////////////////////////////////////////////////////////////////////////

package vram_pkg;

   typedef struct packed {
      logic [7:0] r;                     // high byte
      logic [7:0] g;
      logic [7:0] b;
   } pixel_t;

   localparam int num_banks  = 3;        // banks and write lanes
   typedef logic [1:0] bank_idx_t;       // bank pointer

   localparam int bank_depth = 64;       // entries per bank
   localparam int used_w     = 7;        // holds 0 .. bank_depth
   localparam int vram_size  = num_banks * bank_depth;
   localparam int max_burst  = 6;        // headroom kept by vram_ready
   localparam int count_w    = 24;       // frame pixel count and queue

   // shown when a visible pixel finds its bank empty
   localparam pixel_t no_vram_pixel = '{r: 8'hFF, g: 8'h00, b: 8'h00};

endpackage

/* hdl/vga_ifs.sv */
// Internal video interfaces

`timescale 1ns/1ps

//////////////////////////////////////////////////////////////////////////////
// one FIFO bank, written by the input side and read by the output side
//////////////////////////////////////////////////////////////////////////////

interface pixel_bank_if;

   logic                        wr;      // push strobe
   vram_pkg::pixel_t            wdata;
   logic                        rd;      // pop strobe
   vram_pkg::pixel_t            q;       // head entry, valid while !empty
   logic                        empty;
   logic [vram_pkg::used_w-1:0] used;    // entries held

   modport writer (output wr, output wdata, input used);
   modport fifo   (input wr, input wdata, input rd, output q, output empty, output used);
   modport reader (output rd, input q, input empty);

endinterface

//////////////////////////////////////////////////////////////////////////////
// blanking state from the timing generator
//////////////////////////////////////////////////////////////////////////////

interface video_timing_if;

   logic de;                             // visible area
   logic hblank;
   logic vblank;
   logic frame_tick;                     // one pixel-enable per frame

   modport producer (output de, output hblank, output vblank, output frame_tick);
   modport consumer (input de, input hblank, input vblank, input frame_tick);

endinterface

/* hdl/pixel_fifo.sv */
// First-word-fall-through pixel bank

`timescale 1ns/1ps

module pixel_fifo (
   input  logic        clk_sys,
   input  logic        vga_reset,
   input  logic        vram_reset,
   pixel_bank_if.fifo  bank
);

   vram_pkg::pixel_t                          mem [vram_pkg::bank_depth];
   logic [$clog2(vram_pkg::bank_depth)-1:0]   wptr, rptr;
   logic                                      push, pop, full;

   assign full       = bank.used == vram_pkg::used_w'(vram_pkg::bank_depth);
   assign push       = bank.wr && !full;              // writes to a full bank are lost
   assign pop        = bank.rd && !bank.empty;
   assign bank.empty = bank.used == '0;
   assign bank.q     = mem[rptr];                     // head shows without a read

   always_ff @(posedge clk_sys) begin
      if (vga_reset || vram_reset) begin
         wptr      <= '0;
         rptr      <= '0;
         bank.used <= '0;
      end else begin
         if (push)
            wptr <= wptr + 1;                         // wraps at bank_depth
         if (pop)
            rptr <= rptr + 1;
         case ({push, pop})
            2'b10:   bank.used <= bank.used + 1;
            2'b01:   bank.used <= bank.used - 1;
            default: bank.used <= bank.used;
         endcase
      end
   end

   always_ff @(posedge clk_sys) begin
      if (push)
         mem[wptr] <= bank.wdata;
   end

endmodule

/* hdl/pixel_writer.sv */
// Pixel store input side

`timescale 1ns/1ps

module pixel_writer (
   input  logic                                        clk_sys,
   input  logic                                        vga_reset,
   input  logic                                        vram_reset,
   input  logic [video_pkg::hcnt_w-1:0]                h_active,
   input  logic [video_pkg::hcnt_w-1:0]                v_active,
   input  logic [vram_pkg::num_banks-1:0]              wren,
   input  vram_pkg::pixel_t [vram_pkg::num_banks-1:0]  wpix,
   pixel_bank_if.writer                                banks [vram_pkg::num_banks],
   output logic [vram_pkg::count_w-1:0]                vram_pixels,
   output logic                                        vram_end_frame,
   output logic [vram_pkg::count_w-1:0]                vga_pixels,
   output logic [vram_pkg::count_w-1:0]                vram_queue,
   output logic                                        vram_ready
);

   logic                                store_reset;
   vram_pkg::bank_idx_t                 wptr;             // bank for lane 1
   logic [1:0]                          lanes;            // lanes written this cycle
   logic [vram_pkg::num_banks-1:0]      wr_d, wr_q;
   vram_pkg::pixel_t                    wdata_d [vram_pkg::num_banks];
   vram_pkg::pixel_t                    wdata_q [vram_pkg::num_banks];
   logic [vram_pkg::used_w-1:0]         used_a [vram_pkg::num_banks];
   logic [vram_pkg::count_w-1:0]        used_sum;

   function automatic vram_pkg::bank_idx_t wrap_add(vram_pkg::bank_idx_t base, logic [1:0] n);
      logic [2:0] s;
      s = {1'b0, base} + {1'b0, n};
      if (s >= 3'(vram_pkg::num_banks))
         s = s - 3'(vram_pkg::num_banks);
      return s[1:0];
   endfunction

   assign store_reset    = vga_reset | vram_reset;
   assign lanes          = 2'($countones(wren));      // lanes are contiguous from lane 1
   assign vram_end_frame = vram_pixels >= vga_pixels;
   assign vram_ready     = vram_queue < vram_pkg::count_w'(vram_pkg::vram_size - vram_pkg::max_burst);

   ///////////////////////////////////////////////////////////////////////////
   // lane k goes to bank wptr+k, keeping pixel order across the banks
   ///////////////////////////////////////////////////////////////////////////

   always_comb begin
      vram_pkg::bank_idx_t idx;
      wr_d = '0;
      for (int b = 0; b < vram_pkg::num_banks; b++)
         wdata_d[b] = wpix[0];
      for (int k = 0; k < vram_pkg::num_banks; k++) begin
         idx = wrap_add(wptr, 2'(k));
         if (wren[k]) begin
            wr_d[idx]    = 1'b1;
            wdata_d[idx] = wpix[k];
         end
      end
   end

   always_comb begin
      used_sum = '0;
      for (int i = 0; i < vram_pkg::num_banks; i++)
         used_sum = used_sum + vram_pkg::count_w'(used_a[i]);
   end

   always_ff @(posedge clk_sys) begin
      if (store_reset) begin
         wr_q        <= '0;
         wptr        <= '0;
         vram_pixels <= '0;
         vram_queue  <= '0;
         vga_pixels  <= vram_pkg::count_w'(h_active) * vram_pkg::count_w'(v_active);
      end else begin
         wr_q       <= wr_d;
         wptr       <= wrap_add(wptr, lanes);
         vram_queue <= used_sum;                      // one cycle behind the banks
         if (lanes != 2'd0)
            vram_pixels <= vram_end_frame ? vram_pkg::count_w'(lanes)
                                          : vram_pixels + vram_pkg::count_w'(lanes);
      end
   end

   always_ff @(posedge clk_sys) begin
      wdata_q <= wdata_d;                             // payload only
   end

   for (genvar i = 0; i < vram_pkg::num_banks; i++) begin : g_bank
      assign banks[i].wr    = wr_q[i];
      assign banks[i].wdata = wdata_q[i];
      assign used_a[i]      = banks[i].used;
   end

endmodule

/* hdl/video_timing.sv */
// Video timing generator

`timescale 1ns/1ps

module video_timing (
   input  logic                           clk_sys,
   input  logic                           ce_pix,
   input  logic                           vga_reset,
   input  logic [video_pkg::hcnt_w-1:0]   h_active,
   input  logic [video_pkg::porch_w-1:0]  h_front,
   input  logic [video_pkg::porch_w-1:0]  h_sync,
   input  logic [video_pkg::porch_w-1:0]  h_back,
   input  logic [video_pkg::hcnt_w-1:0]   v_active,
   input  logic [video_pkg::porch_w-1:0]  v_front,
   input  logic [video_pkg::porch_w-1:0]  v_sync,
   input  logic [video_pkg::porch_w-1:0]  v_back,
   video_timing_if.producer               vt,
   output logic                           hsync,
   output logic                           vsync,
   output logic [video_pkg::hcnt_w-1:0]   vcount
);

   logic [video_pkg::hcnt_w-1:0] h_cnt, v_cnt, v_next;
   logic [video_pkg::hcnt_w-1:0] hs_start, hs_end, h_total;
   logic [video_pkg::hcnt_w-1:0] vs_start, vs_end, v_total;
   logic                         hb, vb;

   ///////////////////////////////////////////////////////////////////////////
   // modeline boundaries, counted from the start of the visible area
   ///////////////////////////////////////////////////////////////////////////

   assign hs_start = h_active + video_pkg::hcnt_w'(h_front);
   assign hs_end   = hs_start + video_pkg::hcnt_w'(h_sync);
   assign h_total  = hs_end + video_pkg::hcnt_w'(h_back);
   assign vs_start = v_active + video_pkg::hcnt_w'(v_front);
   assign vs_end   = vs_start + video_pkg::hcnt_w'(v_sync);
   assign v_total  = vs_end + video_pkg::hcnt_w'(v_back);

   assign v_next   = (v_cnt >= v_total - 1) ? '0 : v_cnt + 1;

   always_ff @(posedge clk_sys) begin
      if (vga_reset) begin
         h_cnt <= '0;
         v_cnt <= '0;
         hb    <= 1'b1;
         vb    <= 1'b1;
         hsync <= 1'b1;                               // inactive
         vsync <= 1'b1;
      end else if (ce_pix) begin
         h_cnt <= (h_cnt >= h_total - 1) ? '0 : h_cnt + 1;
         hb    <= h_cnt >= h_active;                  // one pixel-enable behind h_cnt
         hsync <= !(h_cnt >= hs_start && h_cnt < hs_end);

         // lines change at the start of hsync
         if (h_cnt == hs_start) begin
            v_cnt <= v_next;
            vb    <= v_next >= v_active;
            vsync <= !(v_next >= vs_start && v_next < vs_end);
         end
      end
   end

   assign vt.de         = !(hb || vb);
   assign vt.hblank     = hb;
   assign vt.vblank     = vb;
   assign vt.frame_tick = (h_cnt == hs_start) && (v_cnt == '0);   // hsync start of line 0
   assign vcount        = v_cnt;

endmodule

/* hdl/pixel_output.sv */
// Pixel output and frame counter

`timescale 1ns/1ps

module pixel_output (
   input  logic                      clk_sys,
   input  logic                      ce_pix,
   input  logic                      vga_reset,
   input  logic                      vram_reset,
   input  logic                      vram_active,
   video_timing_if.consumer          vt,
   pixel_bank_if.reader              banks [vram_pkg::num_banks],
   input  vram_pkg::pixel_t          pass_pix,
   output vram_pkg::pixel_t          pix,
   output logic                      vram_synced,
   output logic [31:0]               vga_frame
);

   logic                             started;         // store has held a pixel
   logic                             wait_vblank;     // hold off until next vblank
   logic                             show;            // visible pixel from the store
   vram_pkg::bank_idx_t              rptr;
   logic [vram_pkg::num_banks-1:0]   empty_a, rd_a;
   vram_pkg::pixel_t                 q_a [vram_pkg::num_banks];

   assign show = vram_active && vt.de && started && !wait_vblank;

   // pop the current bank on the same pixel-enable that shows it
   always_comb begin
      rd_a = '0;
      if (ce_pix && show && !empty_a[rptr])
         rd_a[rptr] = 1'b1;
   end

   ///////////////////////////////////////////////////////////////////////////
   // store readout state
   ///////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk_sys) begin
      if (vga_reset || vram_reset) begin
         started     <= 1'b0;
         wait_vblank <= 1'b1;
         vram_synced <= 1'b1;
         rptr        <= '0;
      end else if (ce_pix) begin
         if (!vram_active) begin
            wait_vblank <= 1'b1;                      // resync on return to vram mode
         end else begin
            if (!started && !(&empty_a))
               started <= 1'b1;
            if (started && vt.vblank)
               wait_vblank <= 1'b0;
            if (show && empty_a[rptr])
               vram_synced <= 1'b0;                   // underflow
            else if (show)
               rptr <= (rptr == vram_pkg::bank_idx_t'(vram_pkg::num_banks - 1)) ? '0 : rptr + 1;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (vga_reset) begin
         pix       <= '0;
         vga_frame <= '0;
      end else if (ce_pix) begin
         if (!vram_active)
            pix <= vt.de ? pass_pix : '0;             // pass-through
         else if (show)
            pix <= empty_a[rptr] ? vram_pkg::no_vram_pixel : q_a[rptr];
         else
            pix <= '0;                                // blank or not started
         if (vt.frame_tick && vram_active && started)
            vga_frame <= vga_frame + 1;
      end
   end

   for (genvar i = 0; i < vram_pkg::num_banks; i++) begin : g_bank
      assign q_a[i]       = banks[i].q;
      assign empty_a[i]   = banks[i].empty;
      assign banks[i].rd  = rd_a[i];
   end

endmodule

/* hdl/vga_top.sv */
// Video timing generator with pixel store

`timescale 1ns/1ps

module vga_top (
   input  logic                           clk_sys,
   input  logic                           ce_pix,
   input  logic                           vga_reset,
   input  logic                           vram_reset,
   input  logic                           vram_active,
   input  logic [video_pkg::hcnt_w-1:0]   h_active,
   input  logic [video_pkg::porch_w-1:0]  h_front,
   input  logic [video_pkg::porch_w-1:0]  h_sync,
   input  logic [video_pkg::porch_w-1:0]  h_back,
   input  logic [video_pkg::hcnt_w-1:0]   v_active,
   input  logic [video_pkg::porch_w-1:0]  v_front,
   input  logic [video_pkg::porch_w-1:0]  v_sync,
   input  logic [video_pkg::porch_w-1:0]  v_back,
   input  logic                           vram_wren1,
   input  logic [7:0]                     r_vram_in1,
   input  logic [7:0]                     g_vram_in1,
   input  logic [7:0]                     b_vram_in1,
   input  logic                           vram_wren2,
   input  logic [7:0]                     r_vram_in2,
   input  logic [7:0]                     g_vram_in2,
   input  logic [7:0]                     b_vram_in2,
   input  logic                           vram_wren3,
   input  logic [7:0]                     r_vram_in3,
   input  logic [7:0]                     g_vram_in3,
   input  logic [7:0]                     b_vram_in3,
   input  logic [7:0]                     r_in,
   input  logic [7:0]                     g_in,
   input  logic [7:0]                     b_in,
   output logic                           vram_ready,
   output logic [vram_pkg::count_w-1:0]   vram_pixels,
   output logic [vram_pkg::count_w-1:0]   vram_queue,
   output logic                           vram_end_frame,
   output logic                           vram_synced,
   output logic [vram_pkg::count_w-1:0]   vga_pixels,
   output logic [31:0]                    vga_frame,
   output logic [video_pkg::hcnt_w-1:0]   vcount,
   output logic                           hsync,
   output logic                           vsync,
   output logic [7:0]                     r,
   output logic [7:0]                     g,
   output logic [7:0]                     b,
   output logic                           vga_de,
   output logic                           hblank,
   output logic                           vblank
);

   vram_pkg::pixel_t [vram_pkg::num_banks-1:0] wpix;
   vram_pkg::pixel_t                           pass_pix, pix;

   pixel_bank_if   banks [vram_pkg::num_banks] ();
   video_timing_if vt ();

   // lane 1 in the low slot
   assign wpix[0]  = '{r: r_vram_in1, g: g_vram_in1, b: b_vram_in1};
   assign wpix[1]  = '{r: r_vram_in2, g: g_vram_in2, b: b_vram_in2};
   assign wpix[2]  = '{r: r_vram_in3, g: g_vram_in3, b: b_vram_in3};
   assign pass_pix = '{r: r_in, g: g_in, b: b_in};

   //////////////////////////////////////////////////////////////////////////
   // store, timing and output side
   //////////////////////////////////////////////////////////////////////////

   pixel_writer writer_i (
      .clk_sys, .vga_reset, .vram_reset, .h_active, .v_active,
      .wren           ({vram_wren3, vram_wren2, vram_wren1}),
      .wpix           (wpix),
      .banks          (banks),
      .vram_pixels, .vram_end_frame, .vga_pixels, .vram_queue, .vram_ready
   );

   for (genvar i = 0; i < vram_pkg::num_banks; i++) begin : g_fifo
      pixel_fifo fifo_i (
         .clk_sys, .vga_reset, .vram_reset,
         .bank (banks[i])
      );
   end

   video_timing timing_i (
      .clk_sys, .ce_pix, .vga_reset,
      .h_active, .h_front, .h_sync, .h_back,
      .v_active, .v_front, .v_sync, .v_back,
      .vt             (vt),
      .hsync, .vsync, .vcount
   );

   pixel_output output_i (
      .clk_sys, .ce_pix, .vga_reset, .vram_reset, .vram_active,
      .vt             (vt),
      .banks          (banks),
      .pass_pix       (pass_pix),
      .pix            (pix),
      .vram_synced, .vga_frame
   );

   assign r      = pix.r;
   assign g      = pix.g;
   assign b      = pix.b;
   assign vga_de = vt.de;
   assign hblank = vt.hblank;
   assign vblank = vt.vblank;

endmodule

/* test/vga_asserts.sv */
// Video output checks

`timescale 1ns/1ps

module vga_asserts (
   input logic                          clk_sys,
   input logic                          ce_pix,
   input logic                          vga_reset,
   input logic                          vga_de,
   input logic                          hblank,
   input logic                          vblank,
   input logic                          hsync,
   input logic                          vsync,
   input logic [7:0]                    r,
   input logic [7:0]                    g,
   input logic [7:0]                    b,
   input logic [vram_pkg::count_w-1:0]  vram_queue
);

   // sync pulses sit inside the blanking intervals
   hsync_in_blank: assert property (@(posedge clk_sys) disable iff (vga_reset)
      hsync || hblank)
      else $error("hsync low outside horizontal blanking");

   vsync_in_blank: assert property (@(posedge clk_sys) disable iff (vga_reset)
      vsync || vblank)
      else $error("vsync low outside vertical blanking");

   // blank pixel-enable clears the colour
   rgb_blank: assert property (@(posedge clk_sys) disable iff (vga_reset)
      (ce_pix && !vga_de) |=> ({r, g, b} == 24'h0))
      else $error("rgb not zero after a blank pixel-enable");

   queue_bound: assert property (@(posedge clk_sys) disable iff (vga_reset)
      vram_queue <= vram_pkg::count_w'(vram_pkg::vram_size))
      else $error("vram_queue above store capacity");

endmodule

bind vga_top vga_asserts asserts_i (.*);

/* test/vga_tb.sv */
// Video top level testbench

`timescale 1ns/1ps

module vga_tb;

   localparam int frame_pe     = 14 * 7;                 // pixel-enables per frame
   localparam int frame_cycles = 2 * frame_pe;           // ce_pix on every other cycle
   localparam int max_cycles   = 20 * frame_cycles + 80;

   logic                           clk_sys;
   logic                           ce_pix;
   logic                           vga_reset;
   logic                           vram_reset;
   logic                           vram_active;
   logic [video_pkg::hcnt_w-1:0]   h_active;
   logic [video_pkg::hcnt_w-1:0]   v_active;
   logic [video_pkg::porch_w-1:0]  h_front;
   logic [video_pkg::porch_w-1:0]  h_sync;
   logic [video_pkg::porch_w-1:0]  h_back;
   logic [video_pkg::porch_w-1:0]  v_front;
   logic [video_pkg::porch_w-1:0]  v_sync;
   logic [video_pkg::porch_w-1:0]  v_back;
   logic                           vram_wren1;
   logic                           vram_wren2;
   logic                           vram_wren3;
   logic [7:0]                     r_vram_in1, g_vram_in1, b_vram_in1;
   logic [7:0]                     r_vram_in2, g_vram_in2, b_vram_in2;
   logic [7:0]                     r_vram_in3, g_vram_in3, b_vram_in3;
   logic [7:0]                     r_in, g_in, b_in;
   logic                           vram_ready;
   logic [vram_pkg::count_w-1:0]   vram_pixels;
   logic [vram_pkg::count_w-1:0]   vram_queue;
   logic                           vram_end_frame;
   logic                           vram_synced;
   logic [vram_pkg::count_w-1:0]   vga_pixels;
   logic [31:0]                    vga_frame;
   logic [video_pkg::hcnt_w-1:0]   vcount;
   logic                           hsync, vsync;
   logic [7:0]                     r, g, b;
   logic                           vga_de, hblank, vblank;

   int          errors       = 0;
   int          tests_run    = 0;
   int          tests_failed = 0;
   int          cycles       = 0;
   logic [23:0] exp_q [$];                               // pixels in write order

   vga_top dut_i (.*);

   always #20 clk_sys = !clk_sys;

   always @(negedge clk_sys)
      ce_pix <= !ce_pix;                                 // every other cycle

   always @(posedge clk_sys) begin
      cycles <= cycles + 1;
      if (cycles >= max_cycles) begin
         $display("timeout: run stopped after %0d cycles with tests still running", cycles);
         $display("Regression failed");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
      errors++;
      $display("MISMATCH %s: got 0x%0h expected 0x%0h", name, got, exp);
   endtask

   task automatic close_test(input string name, input int start);
      int errs;
      errs = errors - start;
      tests_run++;
      if (errs == 0) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d mismatches", name, errs);
      end
   endtask

   // returns on the falling edge after the next pixel-enable
   task automatic next_pe;
      @(posedge clk_sys);
      while (!ce_pix)
         @(posedge clk_sys);
      @(negedge clk_sys);
   endtask

   task automatic write_group(input int lanes);
      logic [23:0] p [3];
      for (int k = 0; k < 3; k++)
         p[k] = 24'($urandom);
      @(negedge clk_sys);
      {r_vram_in1, g_vram_in1, b_vram_in1} = p[0];
      {r_vram_in2, g_vram_in2, b_vram_in2} = p[1];
      {r_vram_in3, g_vram_in3, b_vram_in3} = p[2];
      vram_wren1 = (lanes >= 1);
      vram_wren2 = (lanes >= 2);
      vram_wren3 = (lanes >= 3);
      for (int k = 0; k < lanes; k++)
         exp_q.push_back(p[k]);
      @(negedge clk_sys);
      vram_wren1 = 1'b0;
      vram_wren2 = 1'b0;
      vram_wren3 = 1'b0;
   endtask

   task automatic prepare_store(input logic active);
      exp_q.delete();
      @(negedge clk_sys);
      vram_active = active;
      vram_reset  = 1'b1;
      @(negedge clk_sys);
      vram_reset  = 1'b0;
   endtask

   task automatic wait_for_readout;
      repeat (2) next_pe;                                // store seen as started
      while (!vblank)
         next_pe;
      next_pe;                                           // readout armed here
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // directed tests
   ////////////////////////////////////////////////////////////////////////////

   task automatic test_timing;
      int   start, de_cnt, hs_cnt, de_run, hs_run, runs;
      int   vs_cnt, hb_cnt, vb_cnt, l0_cnt;
      logic prev_de;
      start  = errors;
      de_cnt = 0;
      hs_cnt = 0;
      de_run = 0;
      hs_run = 0;
      runs   = 0;
      vs_cnt = 0;
      hb_cnt = 0;
      vb_cnt = 0;
      l0_cnt = 0;
      prev_de = vga_de;
      next_pe;
      while (!(vga_de && !prev_de)) begin                // first pixel of a line
         prev_de = vga_de;
         next_pe;
      end
      for (int i = 0; i < 2 * frame_pe; i++) begin
         if (vga_de) begin
            de_cnt++;
            de_run++;
         end else if (de_run != 0) begin
            if (de_run != 8)
               report_mismatch("vga_de run length", 32'(de_run), 32'd8);
            runs++;
            de_run = 0;
         end
         if (!hsync) begin
            hs_cnt++;
            hs_run++;
         end else if (hs_run != 0) begin
            if (hs_run != 2)
               report_mismatch("hsync low length", 32'(hs_run), 32'd2);
            hs_run = 0;
         end
         if (!vsync) begin
            vs_cnt++;
            if (vcount !== 16'd5)                        // v_active + v_front
               report_mismatch("vcount in vsync", 32'(vcount), 32'd5);
         end
         if (hblank)
            hb_cnt++;
         if (vblank)
            vb_cnt++;
         if (vcount == 16'd0)
            l0_cnt++;
         next_pe;
      end
      if (de_cnt != 64)
         report_mismatch("vga_de count", 32'(de_cnt), 32'd64);
      if (hs_cnt != 28)
         report_mismatch("hsync low count", 32'(hs_cnt), 32'd28);
      if (runs != 8)
         report_mismatch("visible lines", 32'(runs), 32'd8);
      if (vs_cnt != 28)                                  // one line per frame
         report_mismatch("vsync low count", 32'(vs_cnt), 32'd28);
      if (hb_cnt != 84)                                  // 6 of 14 on every line
         report_mismatch("hblank count", 32'(hb_cnt), 32'd84);
      if (vb_cnt != 84)                                  // 3 of 7 lines
         report_mismatch("vblank count", 32'(vb_cnt), 32'd84);
      if (l0_cnt != 28)
         report_mismatch("vcount line 0 count", 32'(l0_cnt), 32'd28);
      close_test("timing", start);
   endtask

   task automatic test_pass_through;
      int          start;
      logic        prev_de;
      logic [23:0] prev_in, exp_pix;
      start   = errors;
      prev_de = 1'b0;
      prev_in = '0;
      vram_active = 1'b0;
      next_pe;
      for (int i = 0; i <= 2 * frame_pe; i++) begin
         exp_pix = prev_de ? prev_in : 24'h0;
         if (i > 0 && {r, g, b} !== exp_pix)
            report_mismatch("rgb", 32'({r, g, b}), 32'(exp_pix));
         prev_de = vga_de;
         prev_in = 24'($urandom);
         {r_in, g_in, b_in} = prev_in;
         next_pe;
      end
      close_test("pass_through", start);
   endtask

   task automatic test_counters;
      int          start, total, n, idx, exp_queue;
      int          pat [6] = '{1, 3, 2, 2, 1, 3};
      logic [23:0] exp_pixels;
      start      = errors;
      total      = 0;
      idx        = 0;
      exp_pixels = '0;
      prepare_store(1'b0);
      if (vga_pixels !== 24'd32)
         report_mismatch("vga_pixels", 32'(vga_pixels), 32'd32);
      while (total < 196) begin
         n = pat[idx % 6];
         write_group(n);
         exp_pixels = (exp_pixels >= 24'd32) ? 24'(n) : exp_pixels + 24'(n);
         total += n;
         exp_queue = (total > 192) ? 192 : total;        // all banks full past 192
         if (vram_pixels !== exp_pixels)
            report_mismatch("vram_pixels", 32'(vram_pixels), 32'(exp_pixels));
         if (vram_end_frame !== (exp_pixels >= 24'd32))
            report_mismatch("vram_end_frame", 32'(vram_end_frame), 32'(exp_pixels >= 24'd32));
         repeat (2) @(negedge clk_sys);                  // queue settles
         if (vram_queue !== 24'(exp_queue))
            report_mismatch("vram_queue", 32'(vram_queue), 32'(exp_queue));
         if (vram_ready !== (total < 186))
            report_mismatch("vram_ready", 32'(vram_ready), 32'(total < 186));
         idx++;
      end
      exp_q.delete();
      close_test("counters", start);
   endtask

   task automatic test_readout;
      int          start, shown, n;
      int          pat [3] = '{2, 3, 1};
      logic        prev_de;
      logic [23:0] exp_pix;
      start = errors;
      shown = 0;
      n     = 0;
      prepare_store(1'b1);
      while (!vga_de)
         next_pe;
      while (exp_q.size() < 32) begin
         write_group((32 - exp_q.size() < pat[n % 3]) ? 32 - exp_q.size() : pat[n % 3]);
         n++;
      end
      wait_for_readout;
      while (shown < 32) begin
         prev_de = vga_de;
         next_pe;
         if (prev_de) begin
            exp_pix = exp_q.pop_front();
            shown++;
            if ({r, g, b} !== exp_pix)
               report_mismatch("rgb", 32'({r, g, b}), 32'(exp_pix));
         end
         if (vram_synced !== 1'b1)
            report_mismatch("vram_synced", 32'(vram_synced), 32'd1);
      end
      close_test("readout", start);
   endtask

   task automatic test_underflow;
      int          start, shown;
      logic        prev_de;
      logic [23:0] exp_pix;
      logic [31:0] frame0;
      start = errors;
      shown = 0;
      prepare_store(1'b1);
      while (!vga_de)
         next_pe;
      write_group(2);
      write_group(3);
      wait_for_readout;
      frame0 = vga_frame;
      for (int i = 0; i < 3 * frame_pe; i++) begin
         prev_de = vga_de;
         next_pe;
         if (prev_de) begin
            shown++;
            exp_pix = (shown <= 5) ? exp_q.pop_front() : 24'hFF0000;
            if ({r, g, b} !== exp_pix)
               report_mismatch("rgb", 32'({r, g, b}), 32'(exp_pix));
            if (vram_synced !== (shown <= 5))
               report_mismatch("vram_synced", 32'(vram_synced), 32'(shown <= 5));
         end
      end
      if (vga_frame !== frame0 + 32'd3)
         report_mismatch("vga_frame", vga_frame, frame0 + 32'd3);
      close_test("underflow", start);
   endtask

   initial begin
      clk_sys     = 1'b0;
      ce_pix      = 1'b0;
      vga_reset   = 1'b1;
      vram_reset  = 1'b0;
      vram_active = 1'b0;
      h_active    = 16'd8;
      h_front     = 8'd2;
      h_sync      = 8'd2;
      h_back      = 8'd2;
      v_active    = 16'd4;
      v_front     = 8'd1;
      v_sync      = 8'd1;
      v_back      = 8'd1;
      vram_wren1  = 1'b0;
      vram_wren2  = 1'b0;
      vram_wren3  = 1'b0;
      {r_vram_in1, g_vram_in1, b_vram_in1} = '0;
      {r_vram_in2, g_vram_in2, b_vram_in2} = '0;
      {r_vram_in3, g_vram_in3, b_vram_in3} = '0;
      {r_in, g_in, b_in} = '0;
      void'($urandom(34437));
      repeat (8) @(negedge clk_sys);
      vga_reset = 1'b0;

      test_timing;
      test_pass_through;
      test_counters;
      test_readout;
      test_underflow;

      $display("summary: %0d tests run, %0d failed, %0d mismatches",
               tests_run, tests_failed, errors);
      if (tests_failed == 0 && errors == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

/* build.f */
hdl/video_pkg.sv
hdl/vram_pkg.sv
hdl/vga_ifs.sv
hdl/pixel_fifo.sv
hdl/pixel_writer.sv
hdl/video_timing.sv
hdl/pixel_output.sv
hdl/vga_top.sv
test/vga_asserts.sv
test/vga_tb.sv

/* Makefile */
# Verilator build and run for the video timing generator

VERILATOR ?= verilator
TOP       ?= vga_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
